// File: vlog.f
+incdir+src
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_way.sv
src/icache_plru.sv
src/icache_refill.sv
src/icache_hit_select.sv
src/icache_top.sv
bench/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module icache_tb -f vlog.f \
    -o icache_sim > build.log 2>&1 \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"

// File: bench/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb import icache_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;

    logic   clk;
    logic   rst;
    logic   req;
    index_t index;
    tag_t   tag;
    logic   index_ok;
    logic   data_ok;
    line_t  rdata;
    logic   arvalid;
    addr_t  araddr;
    logic   arready;
    logic   rvalid;
    word_t  rdata_axi;
    logic   rlast;
    logic   rready;

    int seed;
    int cycle;
    int checks;
    int errors;
    int ar_count;
    int test_ar;
    int test_err;

    // expected results in request order
    line_t exp_line  [$];
    int    exp_cycle [$];
    addr_t exp_addr  [$];

    // reference model of tags, valid bits and tree bits
    tag_t       m_tag   [`ICACHE_LINES][`ICACHE_WAYS];
    logic       m_valid [`ICACHE_LINES][`ICACHE_WAYS];
    plru_bits_t m_plru  [`ICACHE_LINES];
    tag_t       last_evicted;

    icache_top u_icache_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .index     (index),
        .tag       (tag),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata_axi (rdata_axi),
        .rlast     (rlast),
        .rready    (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t mem_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c96e1;
    endfunction

    function automatic line_t ref_line(input index_t idx, input tag_t tg);
        addr_t base;
        line_t l;
        base = {tg, idx, {`ICACHE_OFFSET_W{1'b0}}};
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            l[i*`ICACHE_WORD_W +: `ICACHE_WORD_W] = mem_word(base + addr_t'(4 * i));
        end
        return l;
    endfunction

    // hit or miss; a miss refills the tree victim and turns the tree away from it
    function automatic bit model_lookup(input index_t idx, input tag_t tg);
        bit         hit;
        int         v;
        plru_bits_t b;
        hit = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            b = m_plru[idx];
            if (!b[0]) begin
                v = b[1] ? 1 : 0;
            end else begin
                v = b[2] ? 3 : 2;
            end
            case (v)
                0:       begin b[1] = 1'b1; b[0] = 1'b1; end
                1:       begin b[1] = 1'b0; b[0] = 1'b1; end
                2:       begin b[2] = 1'b1; b[0] = 1'b0; end
                default: begin b[2] = 1'b0; b[0] = 1'b0; end
            endcase
            last_evicted  = m_tag[idx][v];
            m_tag[idx][v]   = tg;
            m_valid[idx][v] = 1'b1;
            m_plru[idx]     = b;
        end
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and run control
    ////////////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("TB FAILED");
        $finish;
    endtask

    // compare each data_ok line and each accepted read address
    always @(negedge clk) begin : compare
        int due;
        if (rst && data_ok) begin
            if (exp_line.size() == 0) begin
                errors++;
                $display("%0t: data_ok pulsed with no request outstanding", $time);
            end else begin
                check("rdata", rdata, exp_line.pop_front());
                due = exp_cycle.pop_front();
                if (due >= 0) begin
                    check("data_ok_cycle", 128'(cycle), 128'(due));
                end
            end
        end
        if (rst && arvalid && arready) begin
            ar_count++;
            if (exp_addr.size() == 0) begin
                errors++;
                $display("%0t: AXI read of %h was not expected", $time, araddr);
            end else begin
                check("araddr", 128'(araddr), 128'(exp_addr.pop_front()));
            end
        end
    end

    // memory side, random gaps before arready and before each beat
    initial begin : axi_responder
        addr_t addr;
        int    d;
        int    n;
        forever begin
            @(negedge clk);
            if (rst && arvalid) begin
                addr = araddr;
                d = int'($unsigned($random(seed)) % 4);
                repeat (d) @(negedge clk);
                @(posedge clk);
                #1;
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready = 1'b0;
                for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
                    @(negedge clk);
                    d = int'($unsigned($random(seed)) % 4);
                    repeat (d) @(negedge clk);
                    @(posedge clk);
                    #1;
                    rvalid    = 1'b1;
                    rdata_axi = mem_word(addr + addr_t'(4 * i));
                    rlast     = (i == `ICACHE_LINE_WORDS - 1);
                    n = 0;
                    @(negedge clk);
                    while (!rready) begin
                        n++;
                        if (n > WAIT_LIMIT) begin
                            abort_run("rready never rose for a read beat");
                        end
                        @(negedge clk);
                    end
                    @(posedge clk);
                    #1;
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    // one request: index until accepted, then its tag
    task automatic send(input index_t idx, input tag_t tg, input bit timed, output int waited);
        int acc;
        bit hit;
        req    = 1'b1;
        index  = idx;
        waited = 0;
        @(negedge clk);
        while (!index_ok) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("index_ok never rose for a waiting request");
            end
            @(negedge clk);
        end
        acc = cycle;
        @(posedge clk);
        #1;
        req = 1'b0;
        tag = tg;
        hit = model_lookup(idx, tg);
        exp_line.push_back(ref_line(idx, tg));
        exp_cycle.push_back((timed && hit) ? acc + 2 : -1);
        if (!hit) begin
            exp_addr.push_back({tg, idx, {`ICACHE_OFFSET_W{1'b0}}});
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_line.size() != 0 || exp_addr.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("outstanding requests never completed");
            end
        end
        repeat (4) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int reads);
        drain();
        if (reads >= 0) begin
            check("axi_reads", 128'(ar_count - test_ar), 128'(reads));
        end
        $display("test %s: %0d errors", name, errors - test_err);
        test_ar  = ar_count;
        test_err = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int     waited;
        tag_t   gone;
        index_t t1_idx [6];
        tag_t   t1_tag [6];
        index_t t3_idx [7];
        tag_t   t3_tag [7];
        rst = 1'b0;
        req = 1'b0;
        index = '0;
        tag = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata_axi = '0;
        rlast = 1'b0;
        seed = 32'hab889038;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            m_plru[i] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                m_tag[i][w]   = '0;
                m_valid[i][w] = 1'b0;
            end
        end
        t1_idx = '{8'h10, 8'h11, 8'h12, 8'h10, 8'hff, 8'h00};
        t1_tag = '{20'h00001, 20'h00001, 20'h00002, 20'h00003, 20'hfffff, 20'h00000};
        t3_idx = '{8'h20, 8'h20, 8'h11, 8'h21, 8'h21, 8'h22, 8'h20};
        t3_tag = '{20'h0aaaa, 20'h0aaaa, 20'h00001, 20'h0bbbb, 20'h0bbbb, 20'h0cccc, 20'h0aaaa};
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        // first request is held through the sweep
        for (int k = 0; k < 6; k++) begin
            send(t1_idx[k], t1_tag[k], 1'b0, waited);
            if (k == 0) begin
                check("sweep_wait_ge_256", 128'(waited >= 256), 128'(1));
            end
        end
        finish_test("1 reset sweep and cold misses", 6);

        for (int k = 0; k < 6; k++) begin
            send(t1_idx[k], t1_tag[k], 1'b1, waited);
            drain();
        end
        finish_test("2 isolated hits", 0);

        // back to back, same line right behind its miss
        for (int k = 0; k < 7; k++) begin
            send(t3_idx[k], t3_tag[k], 1'b0, waited);
        end
        finish_test("3 back-to-back mix", 3);

        for (int k = 0; k < 5; k++) begin
            send(8'h5c, tag_t'(20'h40000 + k), 1'b0, waited);
        end
        gone = last_evicted;
        finish_test("4a five tags on one index", 5);
        send(8'h5c, gone, 1'b0, waited);
        finish_test("4b evicted tag refetch", 1);
        send(8'h5c, 20'h40004, 1'b0, waited);
        finish_test("4c surviving tag", 0);

        for (int k = 0; k < 400; k++) begin
            send(index_t'(8'h80 + $unsigned($random(seed)) % 4),
                 tag_t'(20'h70000 + $unsigned($random(seed)) % 6), 1'b0, waited);
            if ($unsigned($random(seed)) % 4 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        finish_test("5 random stream", -1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top import icache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    // cpu side
    input  logic   req,
    input  index_t index,
    input  tag_t   tag,
    output logic   index_ok,
    output logic   data_ok,
    output line_t  rdata,
    // axi read
    output logic   arvalid,
    output addr_t  araddr,
    input  logic   arready,
    input  logic   rvalid,
    input  word_t  rdata_axi,
    input  logic   rlast,
    output logic   rready
);

    index_t                   array_index;
    way_mask_t                tag_wen;
    way_mask_t                data_wen;
    logic                     wvalid;
    logic                     sda_load;
    tag_t                     sda_tag;
    index_t                   sda_index;
    icache_state_t            state;
    logic                     choose;
    way_mask_t                victim;
    tag_t                     fill_tag;
    line_t                    fill_line;
    logic                     fill_hit;
    way_mask_t                way_hit;
    line_t [`ICACHE_WAYS-1:0] way_line;
    logic                     any_hit;

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .index       (index),
        .tag         (tag),
        .arready     (arready),
        .rvalid      (rvalid),
        .rlast       (rlast),
        .any_hit     (any_hit),
        .fill_hit    (fill_hit),
        .victim      (victim),
        .index_ok    (index_ok),
        .data_ok     (data_ok),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .array_index (array_index),
        .tag_wen     (tag_wen),
        .data_wen    (data_wen),
        .wvalid      (wvalid),
        .sda_load    (sda_load),
        .sda_tag     (sda_tag),
        .sda_index   (sda_index),
        .state       (state),
        .choose      (choose)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ways
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        icache_way u_way (
            .clk         (clk),
            .array_index (array_index),
            .tag_wen     (tag_wen[g]),
            .data_wen    (data_wen[g]),
            .wvalid      (wvalid),
            .wtag        (fill_tag),
            .wline       (fill_line),
            .sda_load    (sda_load),
            .sda_tag     (sda_tag),
            .hit         (way_hit[g]),
            .line        (way_line[g])
        );
    end

    icache_plru u_plru (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .choose    (choose),
        .sda_index (sda_index),
        .victim    (victim)
    );

    icache_refill u_refill (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .sda_tag   (sda_tag),
        .sda_index (sda_index),
        .rvalid    (rvalid),
        .rdata     (rdata_axi),
        .rready    (rready),
        .fill_tag  (fill_tag),
        .fill_line (fill_line),
        .fill_hit  (fill_hit)
    );

    icache_hit_select u_hit_select (
        .hit       (way_hit),
        .lines     (way_line),
        .fill_hit  (fill_hit),
        .fill_line (fill_line),
        .any_hit   (any_hit),
        .rdata     (rdata)
    );

endmodule

// File: src/icache_hit_select.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_hit_select import icache_pkg::*; (
    input  way_mask_t                 hit,
    input  line_t [`ICACHE_WAYS-1:0]  lines,
    input  logic                      fill_hit,
    input  line_t                     fill_line,
    output logic                      any_hit,
    output line_t                     rdata
);

    localparam int SEL_W = $clog2(`ICACHE_WAYS);

    logic [SEL_W-1:0] hit_way;

    assign any_hit = |hit;

    // one-hot to way number
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (hit[i]) begin
                hit_way = SEL_W'(i);
            end
        end
    end

    // refilled line wins over the ways
    assign rdata = fill_hit ? fill_line : lines[hit_way];

endmodule

// File: src/icache_refill.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill import icache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  icache_state_t state,
    input  tag_t          sda_tag,
    input  index_t        sda_index,
    input  logic          rvalid,
    input  word_t         rdata,
    output logic          rready,
    output tag_t          fill_tag,
    output line_t         fill_line,
    output logic          fill_hit
);

    localparam int BEAT_W = $clog2(`ICACHE_LINE_WORDS);

    logic [BEAT_W-1:0]             beat_cnt;
    logic [`ICACHE_LINE_WORDS-1:0] word_valid;
    word_t [`ICACHE_LINE_WORDS-1:0] fill_words;
    index_t                        fill_index;
    logic                          beat;

    assign rready = (state == REFILL);
    assign beat   = rvalid && rready;

    // line under refill
    always_ff @(posedge clk) begin
        if (state == MISS) begin
            fill_tag   <= sda_tag;
            fill_index <= sda_index;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat collection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_cnt <= '0;
        end else if (state == MISS) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + BEAT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            word_valid <= '0;
        end else if (beat) begin
            word_valid[beat_cnt] <= 1'b1;
        end else if (state == FINISH) begin
            word_valid <= '0;
        end
    end

    // beats come in as words 0 to 3
    always_ff @(posedge clk) begin
        if (beat) begin
            fill_words[beat_cnt] <= rdata;
        end
    end

    assign fill_line = fill_words;
    assign fill_hit  = (&word_valid) && (fill_tag == sda_tag) && (fill_index == sda_index);

endmodule

// File: src/icache_plru.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_plru import icache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  icache_state_t state,
    input  logic          choose,
    input  index_t        sda_index,
    output way_mask_t     victim
);

    plru_bits_t plru_mem [`ICACHE_LINES];
    plru_bits_t cur_bits;

    assign cur_bits = plru_mem[sda_index];

    // bit 0 picks the half, bits 1 and 2 the way inside it
    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if (choose) begin
            if (!cur_bits[0]) begin
                victim <= cur_bits[1] ? 4'b0010 : 4'b0001;
            end else begin
                victim <= cur_bits[2] ? 4'b1000 : 4'b0100;
            end
        end
    end

    // point the tree away from the way being refilled
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                plru_mem[i] <= '0;
            end
        end else if (state == MISS) begin
            case (victim)
                4'b0001: plru_mem[sda_index] <= {cur_bits[2], 1'b1, 1'b1};
                4'b0010: plru_mem[sda_index] <= {cur_bits[2], 1'b0, 1'b1};
                4'b0100: plru_mem[sda_index] <= {1'b1, cur_bits[1], 1'b0};
                4'b1000: plru_mem[sda_index] <= {1'b0, cur_bits[1], 1'b0};
                default: plru_mem[sda_index] <= cur_bits;
            endcase
        end
    end

endmodule

// File: src/icache_way.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_way import icache_pkg::*; (
    input  logic   clk,
    input  index_t array_index,
    input  logic   tag_wen,
    input  logic   data_wen,
    input  logic   wvalid,
    input  tag_t   wtag,
    input  line_t  wline,
    input  logic   sda_load,
    input  tag_t   sda_tag,
    output logic   hit,
    output line_t  line
);

    tag_t  tag_mem   [`ICACHE_LINES];
    logic  valid_mem [`ICACHE_LINES];
    line_t data_mem  [`ICACHE_LINES];

    // registered array read
    tag_t  rd_tag;
    logic  rd_valid;
    line_t rd_line;

    // data-stage copy
    tag_t  cp_tag;
    logic  cp_valid;
    line_t cp_line;

    ////////////////////////////////////////////////////////////////////////////
    // tag/valid and data arrays
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (tag_wen) begin
            tag_mem[array_index]   <= wtag;
            valid_mem[array_index] <= wvalid;
        end
        // read returns the old entry on a same-cycle write
        rd_tag   <= tag_mem[array_index];
        rd_valid <= valid_mem[array_index];
    end

    always_ff @(posedge clk) begin
        if (data_wen) begin
            data_mem[array_index] <= wline;
        end
        rd_line <= data_mem[array_index];
    end

    ////////////////////////////////////////////////////////////////////////////
    // data stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (sda_load) begin
            cp_tag   <= rd_tag;
            cp_valid <= rd_valid;
            cp_line  <= rd_line;
        end
    end

    assign hit  = cp_valid && (cp_tag == sda_tag);
    assign line = cp_line;

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          req,
    input  index_t        index,
    input  tag_t          tag,
    input  logic          arready,
    input  logic          rvalid,
    input  logic          rlast,
    input  logic          any_hit,
    input  logic          fill_hit,
    input  way_mask_t     victim,
    output logic          index_ok,
    output logic          data_ok,
    output logic          arvalid,
    output addr_t         araddr,
    output index_t        array_index,
    output way_mask_t     tag_wen,
    output way_mask_t     data_wen,
    output logic          wvalid,
    output logic          sda_load,
    output tag_t          sda_tag,
    output index_t        sda_index,
    output icache_state_t state,
    output logic          choose
);

    logic   sta_req;
    index_t sta_index;
    logic   sda_req;
    index_t sweep_cnt;
    logic   advance;

    ////////////////////////////////////////////////////////////////////////////
    // handshake with the cpu
    ////////////////////////////////////////////////////////////////////////////

    // way hits only count once the copies are fresh
    assign data_ok  = sda_req && (((state == RUN) && any_hit) || fill_hit);
    // pipe moves in RUN, and in FINISH when the refilled line returns
    assign advance  = ((state == RUN) || (state == FINISH)) && (!sda_req || data_ok);
    assign index_ok = req && advance;
    assign choose   = (state == RUN) && sda_req && !any_hit;

    // tag stage and data stage
    always_ff @(posedge clk) begin
        if (!rst) begin
            sta_req <= 1'b0;
            sda_req <= 1'b0;
        end else if (advance) begin
            sta_req <= req;
            sda_req <= sta_req;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            sta_index <= index;
            sda_index <= sta_index;
            // tag of the request leaving the tag stage
            sda_tag   <= tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= RESET;
        end else begin
            case (state)
                RESET:   if (sweep_cnt == index_t'(`ICACHE_LINES - 1)) state <= IDLE;
                IDLE:    state <= RUN;
                RUN:     if (choose) state <= MISS;
                MISS:    if (arready) state <= REFILL;
                REFILL:  if (rvalid && rlast) state <= FINISH;
                // write back, re-read for the waiting request, reload copies
                FINISH:  state <= RECOVER;
                RECOVER: state <= IDLE;
                default: state <= RESET;
            endcase
        end
    end

    // invalidate sweep, one line per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_cnt <= '0;
        end else if (state == RESET) begin
            sweep_cnt <= sweep_cnt + index_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // array steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            RESET:   array_index = sweep_cnt;
            RUN:     array_index = index;
            IDLE:    array_index = sta_index;
            default: array_index = sda_index;
        endcase
    end

    assign tag_wen  = (state == RESET)  ? '1 :
                      (state == FINISH) ? victim : '0;
    assign data_wen = (state == FINISH) ? victim : '0;
    assign wvalid   = (state != RESET);
    // IDLE picks up the re-read done in RECOVER
    assign sda_load = advance || (state == IDLE);

    // aligned 4-beat line read
    assign arvalid  = (state == MISS);
    assign araddr   = {sda_tag, sda_index, {`ICACHE_OFFSET_W{1'b0}}};

endmodule

// File: src/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] addr_t;

    // word 0 sits in the low bits of a line
    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [`ICACHE_WAYS-1:0]   way_mask_t;
    // tree bits, one per inner node
    typedef logic [`ICACHE_WAYS-2:0]   plru_bits_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        RUN,
        MISS,
        REFILL,
        FINISH,
        RECOVER
    } icache_state_t;

endpackage

// File: src/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////////////////////

// 4 ways of 256 lines
`define ICACHE_WAYS       4
`define ICACHE_LINES      256

// address split
`define ICACHE_INDEX_W    8
`define ICACHE_TAG_W      20
`define ICACHE_OFFSET_W   4

// one bus beat and one line
`define ICACHE_WORD_W     32
`define ICACHE_LINE_WORDS 4
`define ICACHE_LINE_W     128

`endif
